//--- Makefile
# Verilator build and run of the vector slice testbench

VERILATOR ?= verilator
TOP       ?= vec_unit_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
+incdir+.
vec_pkg.sv
vec_elem_sequencer.sv
vec_reg_file.sv
vec_lane_alu.sv
vec_unit_top.sv
vec_unit_properties.sv
vec_unit_tb.sv

//--- vec_config.svh
//********************************************************************
// sizing macros for the two-lane vector slice
// register file geometry, lane count and the largest vl
//********************************************************************
`ifndef VEC_CONFIG_SVH
`define VEC_CONFIG_SVH

// register file geometry
`define VEC_NUM_REGS   32
`define VEC_VLEN_BYTES 16

// elements handled per cycle
`define VEC_LANES      2

// sew8 spread over a group of eight registers
`define VEC_VL_MAX     128

`endif

//--- vec_elem_sequencer.sv
//********************************************************************
// element sequencer
// latches a command and walks the element offsets two per cycle
//********************************************************************
`timescale 1ns/1ns

module vec_elem_sequencer (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               start,
  input  vec_pkg::vcmd_t     vcmd,
  output vec_pkg::elem_req_t elem_req,
  output logic               busy,
  output logic               done
);
  import vec_pkg::*;

  vcmd_t   cmd_q;
  offset_t offset;
  vl_t     step_off;
  logic    accept;
  logic    last;

  // a start during an operation is dropped
  assign accept = start & ~busy;

  // offset of the pair after this one
  assign step_off = {1'b0, offset} + vl_t'(2);
  assign last     = step_off >= cmd_q.vl;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy   <= 1'b0;
      done   <= 1'b0;
      offset <= '0;
    end else begin
      done <= 1'b0;
      if (accept) begin
        offset <= '0;
        // vl of zero skips straight to done
        if (vcmd.vl == '0) begin
          done <= 1'b1;
        end else begin
          busy <= 1'b1;
        end
      end else if (busy) begin
        if (last) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          offset <= step_off[$bits(offset_t)-1:0];
        end
      end
    end
  end

  // command payload
  always_ff @(posedge CLK) begin
    if (accept) begin
      cmd_q <= vcmd;
    end
  end

  always_comb begin
    elem_req.valid  = busy;
    elem_req.op     = cmd_q.op;
    elem_req.vd     = cmd_q.vd;
    elem_req.vs1    = cmd_q.vs1;
    elem_req.vs2    = cmd_q.vs2;
    elem_req.sew    = cmd_q.sew;
    elem_req.vm     = cmd_q.vm;
    elem_req.vl     = cmd_q.vl;
    elem_req.offset = offset;
    elem_req.scalar = cmd_q.scalar;
  end

endmodule

//--- vec_lane_alu.sv
//********************************************************************
// two-lane element ALU
// per-lane results truncated to sew, mask applied to write enables
//********************************************************************
`timescale 1ns/1ns
`include "vec_config.svh"

module vec_lane_alu (
  input  vec_pkg::elem_req_t elem_req,
  input  vec_pkg::src_ops_t  src_ops,
  output vec_pkg::wb_t       wb
);
  import vec_pkg::*;

  logic [`VEC_LANES-1:0][31:0] raw;

  // keep only the low sew bits
  function automatic logic [31:0] trunc_sew(logic [31:0] v, sew_t sew);
    case (sew)
      SEW32:   return v;
      SEW16:   return {16'h0, v[15:0]};
      default: return {24'h0, v[7:0]};
    endcase
  endfunction

  always_comb begin
    for (int i = 0; i < `VEC_LANES; i++) begin
      // vd = vs2 op vs1, as in the vv forms
      case (elem_req.op)
        VADD:    raw[i] = src_ops.vs2_data[i] + src_ops.vs1_data[i];
        VSUB:    raw[i] = src_ops.vs2_data[i] - src_ops.vs1_data[i];
        VAND:    raw[i] = src_ops.vs2_data[i] & src_ops.vs1_data[i];
        VXOR:    raw[i] = src_ops.vs2_data[i] ^ src_ops.vs1_data[i];
        VMV_X:   raw[i] = elem_req.scalar;
        // element index of this lane
        VID:     raw[i] = {25'd0, elem_req.offset} + 32'(i);
        default: raw[i] = '0;
      endcase
      wb.data[i] = trunc_sew(raw[i], elem_req.sew);
      // unmasked when vm is high
      wb.wen[i]  = elem_req.valid & (elem_req.vm | src_ops.mask[i]);
    end
  end

endmodule

//--- vec_pkg.sv
//********************************************************************
// shared types of the vector slice
// sew and opcode encodings, command, element request,
// source operand and write-back structs
//********************************************************************
`include "vec_config.svh"

package vec_pkg;

  // element width, same encoding as vsew in vtype
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  typedef enum logic [2:0] {
    VADD  = 3'd0,
    VSUB  = 3'd1,
    VAND  = 3'd2,
    VXOR  = 3'd3,
    VMV_X = 3'd4,
    VID   = 3'd5
  } vop_t;

  // element index within a register group
  typedef logic [$clog2(`VEC_VL_MAX)-1:0]   offset_t;
  // vl from 0 up to and including the maximum
  typedef logic [$clog2(`VEC_VL_MAX+1)-1:0] vl_t;

  typedef logic [`VEC_VLEN_BYTES-1:0][7:0] vreg_t;

  typedef struct packed {
    vop_t        op;
    logic [4:0]  vd;
    logic [4:0]  vs1;
    logic [4:0]  vs2;
    sew_t        sew;
    logic        vm;
    vl_t         vl;
    logic [31:0] scalar;
  } vcmd_t;

  // one element pair per cycle
  typedef struct packed {
    logic        valid;
    vop_t        op;
    logic [4:0]  vd;
    logic [4:0]  vs1;
    logic [4:0]  vs2;
    sew_t        sew;
    logic        vm;
    vl_t         vl;
    offset_t     offset;
    logic [31:0] scalar;
  } elem_req_t;

  typedef struct packed {
    logic [`VEC_LANES-1:0][31:0] vs1_data;
    logic [`VEC_LANES-1:0][31:0] vs2_data;
    logic [`VEC_LANES-1:0]       mask;
  } src_ops_t;

  typedef struct packed {
    logic [`VEC_LANES-1:0]       wen;
    logic [`VEC_LANES-1:0][31:0] data;
  } wb_t;

endpackage

//--- vec_reg_file.sv
//********************************************************************
// vector register file, 32 registers of 16 bytes
// sew-dependent register grouping, two-lane operand reads,
// v0 mask bits, tail-limited write-back and an external read port
//********************************************************************
`timescale 1ns/1ns
`include "vec_config.svh"

module vec_reg_file (
  input  logic               CLK,
  input  logic               nRST,
  input  vec_pkg::elem_req_t elem_req,
  output vec_pkg::src_ops_t  src_ops,
  input  vec_pkg::wb_t       wb,
  input  logic [4:0]         rd_vreg,
  input  vec_pkg::offset_t   rd_offset,
  input  vec_pkg::sew_t      rd_sew,
  output logic [31:0]        rd_data
);
  import vec_pkg::*;

  vreg_t [`VEC_NUM_REGS-1:0]    registers;
  vreg_t [`VEC_NUM_REGS-1:0]    next_registers;

  offset_t [`VEC_LANES-1:0]     lane_off;
  logic [`VEC_LANES-1:0][3:0]   lane_pos;
  logic [`VEC_LANES-1:0][4:0]   vs1_idx;
  logic [`VEC_LANES-1:0][4:0]   vs2_idx;
  logic [`VEC_LANES-1:0][4:0]   vd_idx;
  logic [`VEC_LANES-1:0]        in_body;
  logic [`VEC_VLEN_BYTES*8-1:0] v0_bits;

  logic [4:0] rd_idx;
  logic [3:0] rd_pos;

  // which register of the group holds this element
  function automatic logic [2:0] inner_off(offset_t off, sew_t sew);
    case (sew)
      SEW32:   return off[4:2];
      SEW16:   return off[5:3];
      default: return off[6:4];
    endcase
  endfunction

  // byte position inside that register
  function automatic logic [3:0] byte_pos(offset_t off, sew_t sew);
    case (sew)
      SEW32:   return {off[1:0], 2'b00};
      SEW16:   return {off[2:0], 1'b0};
      default: return off[3:0];
    endcase
  endfunction

  function automatic logic [4:0] grp_reg(logic [4:0] base, offset_t off, sew_t sew);
    return base + {2'b00, inner_off(off, sew)};
  endfunction

  // zero-extended element read
  function automatic logic [31:0] read_elem(vreg_t r, logic [3:0] pos, sew_t sew);
    case (sew)
      SEW32:   return r[pos +: 4];
      SEW16:   return {16'h0, r[pos +: 2]};
      default: return {24'h0, r[pos]};
    endcase
  endfunction

  function automatic vreg_t write_elem(vreg_t r, logic [3:0] pos, sew_t sew,
                                       logic [31:0] data);
    vreg_t w;
    w = r;
    case (sew)
      SEW32:   w[pos +: 4] = data;
      SEW16:   w[pos +: 2] = data[15:0];
      default: w[pos]      = data[7:0];
    endcase
    return w;
  endfunction

  // per-lane addressing, lane 1 sits at offset+1
  always_comb begin
    for (int i = 0; i < `VEC_LANES; i++) begin
      lane_off[i] = elem_req.offset + offset_t'(i);
      lane_pos[i] = byte_pos(lane_off[i], elem_req.sew);
      vs1_idx[i]  = grp_reg(elem_req.vs1, lane_off[i], elem_req.sew);
      vs2_idx[i]  = grp_reg(elem_req.vs2, lane_off[i], elem_req.sew);
      vd_idx[i]   = grp_reg(elem_req.vd, lane_off[i], elem_req.sew);
      in_body[i]  = vl_t'(lane_off[i]) < elem_req.vl;
    end
  end

  // mask bits come from v0 as one flat bit string
  assign v0_bits = registers[0];

  always_comb begin
    for (int i = 0; i < `VEC_LANES; i++) begin
      src_ops.vs1_data[i] = read_elem(registers[vs1_idx[i]], lane_pos[i], elem_req.sew);
      src_ops.vs2_data[i] = read_elem(registers[vs2_idx[i]], lane_pos[i], elem_req.sew);
      src_ops.mask[i]     = v0_bits[lane_off[i]];
    end
  end

  // tail elements at or past vl are left alone
  always_comb begin
    next_registers = registers;
    for (int i = 0; i < `VEC_LANES; i++) begin
      if (wb.wen[i] && in_body[i]) begin
        next_registers[vd_idx[i]] = write_elem(next_registers[vd_idx[i]], lane_pos[i],
                                               elem_req.sew, wb.data[i]);
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      registers <= '0;
    end else begin
      registers <= next_registers;
    end
  end

  // observation port
  assign rd_idx  = grp_reg(rd_vreg, rd_offset, rd_sew);
  assign rd_pos  = byte_pos(rd_offset, rd_sew);
  assign rd_data = read_elem(registers[rd_idx], rd_pos, rd_sew);

endmodule

//--- vec_unit_properties.sv
//**********************************************************************
// concurrent checks on the element sequencer
// done width, request range, offset stepping, reset state
//**********************************************************************
`timescale 1ns/1ns

module vec_unit_properties (
  input logic               CLK,
  input logic               nRST,
  input logic               busy,
  input logic               done,
  input vec_pkg::elem_req_t elem_req
);
  import vec_pkg::*;

  // done is a single-cycle pulse
  done_single: assert property (@(posedge CLK) disable iff (!nRST) done |=> !done)
    else $error("done stayed high for a second cycle");

  // no request is issued at or past vl
  valid_below_vl: assert property (@(posedge CLK) disable iff (!nRST)
    elem_req.valid |-> vl_t'(elem_req.offset) < elem_req.vl)
    else $error("element request issued at or past vl");

  // back-to-back requests step one element pair
  offset_step: assert property (@(posedge CLK) disable iff (!nRST)
    elem_req.valid && $past(elem_req.valid) |->
      elem_req.offset == $past(elem_req.offset) + offset_t'(2))
    else $error("element offset did not advance by two");

  // first edge out of reset
  reset_idle: assert property (@(posedge CLK) $rose(nRST) |-> !busy && !done)
    else $error("busy or done high after reset");

endmodule

bind vec_elem_sequencer vec_unit_properties props_i (
  .CLK      (CLK),
  .nRST     (nRST),
  .busy     (busy),
  .done     (done),
  .elem_req (elem_req)
);

//--- vec_unit_tb.sv
//**********************************************************************
// directed testbench of the vector slice
// byte-array reference model, lcg scalars, read-port sweeps,
// handshake timing checks and the run timeout
//**********************************************************************
`timescale 1ns/1ns
`include "vec_config.svh"

module vec_unit_tb;
  import vec_pkg::*;

  // commands and read sweeps take about 1900 cycles, doubled
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int MODEL_BYTES    = `VEC_NUM_REGS * `VEC_VLEN_BYTES;

  logic        CLK;
  logic        nRST;
  logic        start;
  vcmd_t       vcmd;
  logic        busy;
  logic        done;
  logic [4:0]  rd_vreg;
  offset_t     rd_offset;
  sew_t        rd_sew;
  logic [31:0] rd_data;

  // register file as one flat byte string, little endian elements
  logic [7:0]  model [MODEL_BYTES];
  logic [31:0] lcg_state;
  int          error_count;
  int          check_count;
  int          cycle_count;

  vec_unit_top dut_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .start     (start),
    .vcmd      (vcmd),
    .busy      (busy),
    .done      (done),
    .rd_vreg   (rd_vreg),
    .rd_offset (rd_offset),
    .rd_sew    (rd_sew),
    .rd_data   (rd_data)
  );

  always #50 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout, run stopped after %0d cycles", cycle_count);
      $display("errors: %0d  checks: %0d", error_count, check_count);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int elem_bytes(sew_t sew);
    case (sew)
      SEW32:   return 4;
      SEW16:   return 2;
      default: return 1;
    endcase
  endfunction

  // element off of a group starting at vreg, grouping falls out of the flat layout
  function automatic int byte_addr(int vreg, int off, sew_t sew);
    return (vreg * `VEC_VLEN_BYTES + off * elem_bytes(sew)) % MODEL_BYTES;
  endfunction

  function automatic logic [31:0] read_model(int vreg, int off, sew_t sew);
    logic [31:0] v;
    int          a;
    v = '0;
    a = byte_addr(vreg, off, sew);
    for (int b = 0; b < elem_bytes(sew); b++) begin
      v[8*b +: 8] = model[a + b];
    end
    return v;
  endfunction

  function automatic void write_model(int vreg, int off, sew_t sew, logic [31:0] val);
    int a;
    a = byte_addr(vreg, off, sew);
    for (int b = 0; b < elem_bytes(sew); b++) begin
      model[a + b] = val[8*b +: 8];
    end
  endfunction

  function automatic logic mask_bit(int idx);
    return model[idx / 8][idx % 8];
  endfunction

  // vd = vs2 op vs1, truncation happens in write_model
  function automatic logic [31:0] op_result(vcmd_t c, logic [31:0] src2, logic [31:0] src1,
                                            int idx);
    case (c.op)
      VADD:    return src2 + src1;
      VSUB:    return src2 - src1;
      VAND:    return src2 & src1;
      VXOR:    return src2 ^ src1;
      VMV_X:   return c.scalar;
      VID:     return 32'(idx);
      default: return '0;
    endcase
  endfunction

  // both lanes of a pair read before either writes
  function automatic void apply_to_model(vcmd_t c);
    logic [31:0] src1 [`VEC_LANES];
    logic [31:0] src2 [`VEC_LANES];
    logic        wr   [`VEC_LANES];
    for (int p = 0; p < int'(c.vl); p += `VEC_LANES) begin
      for (int l = 0; l < `VEC_LANES; l++) begin
        src1[l] = read_model(int'(c.vs1), p + l, c.sew);
        src2[l] = read_model(int'(c.vs2), p + l, c.sew);
        wr[l]   = (p + l < int'(c.vl)) && (c.vm || mask_bit(p + l));
      end
      for (int l = 0; l < `VEC_LANES; l++) begin
        if (wr[l]) begin
          write_model(int'(c.vd), p + l, c.sew, op_result(c, src2[l], src1[l], p + l));
        end
      end
    end
  endfunction

  function automatic vcmd_t make_cmd(vop_t op, int vd, int vs1, int vs2, sew_t sew,
                                     logic vm, int vl, logic [31:0] scalar);
    vcmd_t c;
    c.op     = op;
    c.vd     = 5'(vd);
    c.vs1    = 5'(vs1);
    c.vs2    = 5'(vs2);
    c.sew    = sew;
    c.vm     = vm;
    c.vl     = vl_t'(vl);
    c.scalar = scalar;
    return c;
  endfunction

  task automatic tick();
    @(posedge CLK);
    #1;
  endtask

  task automatic expect_equal(string name, logic [31:0] expected, logic [31:0] actual);
    check_count++;
    assert (actual == expected) else begin
      error_count++;
      $display("FAILED %s expected 0x%h got 0x%h", name, expected, actual);
    end
  endtask

  task automatic expect_true(logic cond, string what);
    check_count++;
    assert (cond) else begin
      error_count++;
      $display("%s", what);
    end
  endtask

  task automatic run_cmd(vcmd_t c);
    int waited;
    waited = 0;
    vcmd   = c;
    start  = 1'b1;
    tick();
    start = 1'b0;
    while (!done && waited < `VEC_VL_MAX) begin
      tick();
      waited++;
    end
    expect_true(done, "command never raised done");
    apply_to_model(c);
    tick();
  endtask

  task automatic sweep_registers(int first, int count, sew_t sew);
    int per_reg;
    per_reg = `VEC_VLEN_BYTES / elem_bytes(sew);
    for (int r = first; r < first + count; r++) begin
      for (int e = 0; e < per_reg; e++) begin
        rd_vreg   = 5'(r);
        rd_offset = offset_t'(e);
        rd_sew    = sew;
        #20;
        expect_equal($sformatf("rd_data v%0d[%0d] sew%0d", r, e, 8 * elem_bytes(sew)),
                     read_model(r, e, sew), rd_data);
        tick();
      end
    end
  endtask

  task automatic reset_values();
    expect_true(!busy, "busy high after reset");
    expect_true(!done, "done high after reset");
    sweep_registers(0, `VEC_NUM_REGS, SEW8);
    sweep_registers(0, `VEC_NUM_REGS, SEW16);
    sweep_registers(0, `VEC_NUM_REGS, SEW32);
  endtask

  // each group spans eight registers
  task automatic vid_grouping();
    run_cmd(make_cmd(VID, 8, 0, 0, SEW8, 1'b1, 128, 32'h0));
    sweep_registers(8, 8, SEW8);
    run_cmd(make_cmd(VID, 16, 0, 0, SEW16, 1'b1, 64, 32'h0));
    sweep_registers(16, 8, SEW16);
    run_cmd(make_cmd(VID, 24, 0, 0, SEW32, 1'b1, 32, 32'h0));
    sweep_registers(24, 8, SEW32);
  endtask

  task automatic arithmetic_ops(sew_t sew);
    vop_t ops [4];
    int   vl;
    ops = '{VADD, VSUB, VAND, VXOR};
    // two registers worth of elements
    vl = 2 * `VEC_VLEN_BYTES / elem_bytes(sew);
    run_cmd(make_cmd(VMV_X, 2, 0, 0, sew, 1'b1, vl, next_random()));
    run_cmd(make_cmd(VMV_X, 4, 0, 0, sew, 1'b1, vl, next_random()));
    for (int k = 0; k < 4; k++) begin
      run_cmd(make_cmd(ops[k], 6, (k % 2 == 0) ? 8 : 4, 2, sew, 1'b1, vl, 32'h0));
      sweep_registers(6, 2, sew);
    end
  endtask

  task automatic tail_handling();
    // odd vl leaves lane 1 of the last pair untouched
    run_cmd(make_cmd(VMV_X, 20, 0, 0, SEW16, 1'b1, 7, next_random()));
    sweep_registers(20, 2, SEW16);
    run_cmd(make_cmd(VMV_X, 26, 0, 0, SEW32, 1'b1, 5, next_random()));
    sweep_registers(26, 2, SEW32);
  endtask

  task automatic masked_ops();
    run_cmd(make_cmd(VMV_X, 0, 0, 0, SEW32, 1'b1, 4, 32'h5a3c_96f0));
    sweep_registers(0, 1, SEW32);
    run_cmd(make_cmd(VMV_X, 10, 0, 0, SEW8, 1'b0, 32, next_random()));
    sweep_registers(10, 2, SEW8);
    run_cmd(make_cmd(VADD, 17, 2, 17, SEW16, 1'b0, 16, 32'h0));
    sweep_registers(17, 2, SEW16);
    run_cmd(make_cmd(VXOR, 10, 2, 10, SEW8, 1'b1, 24, 32'h0));
    sweep_registers(10, 2, SEW8);
  endtask

  task automatic handshake_timing();
    vcmd_t c;
    vcmd_t other;
    int    busy_cycles;
    c           = make_cmd(VID, 28, 0, 0, SEW32, 1'b1, 9, 32'h0);
    other       = make_cmd(VMV_X, 24, 0, 0, SEW32, 1'b1, 8, 32'hffff_ffff);
    busy_cycles = 0;
    vcmd  = c;
    start = 1'b1;
    tick();
    // start held into the first busy cycle with another command
    vcmd = other;
    while (busy && busy_cycles < `VEC_VL_MAX) begin
      busy_cycles++;
      tick();
      start = 1'b0;
    end
    expect_equal("busy cycles", 32'd5, 32'(busy_cycles));
    expect_true(done, "no done in the cycle after busy fell");
    tick();
    expect_true(!done, "done lasted more than one cycle");
    apply_to_model(c);
    sweep_registers(24, 8, SEW32);
    // vl of zero
    c     = make_cmd(VMV_X, 12, 0, 0, SEW8, 1'b1, 0, 32'hffff_ffff);
    vcmd  = c;
    start = 1'b1;
    tick();
    start = 1'b0;
    expect_true(!busy, "busy rose for a command with vl of zero");
    expect_true(done, "no done for a command with vl of zero");
    tick();
    expect_true(!done, "done lasted more than one cycle with vl of zero");
    sweep_registers(12, 1, SEW8);
  endtask

  initial begin
    CLK         = 1'b0;
    nRST        = 1'b0;
    start       = 1'b0;
    vcmd        = '0;
    rd_vreg     = '0;
    rd_offset   = '0;
    rd_sew      = SEW8;
    lcg_state   = 32'd62212;
    error_count = 0;
    check_count = 0;
    cycle_count = 0;
    for (int a = 0; a < MODEL_BYTES; a++) begin
      model[a] = 8'h00;
    end
    repeat (8) @(posedge CLK);
    #1;
    nRST = 1'b1;
    tick();
    reset_values();
    vid_grouping();
    arithmetic_ops(SEW8);
    arithmetic_ops(SEW16);
    arithmetic_ops(SEW32);
    tail_handling();
    masked_ops();
    handshake_timing();
    $display("errors: %0d  checks: %0d", error_count, check_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- vec_unit_top.sv
//********************************************************************
// top of the vector slice
// element sequencer, register file and lane ALU
//********************************************************************
`timescale 1ns/1ns

module vec_unit_top (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             start,
  input  vec_pkg::vcmd_t   vcmd,
  output logic             busy,
  output logic             done,
  input  logic [4:0]       rd_vreg,
  input  vec_pkg::offset_t rd_offset,
  input  vec_pkg::sew_t    rd_sew,
  output logic [31:0]      rd_data
);
  import vec_pkg::*;

  elem_req_t elem_req;
  src_ops_t  src_ops;
  wb_t       wb;

  vec_elem_sequencer u_seq (
    .CLK      (CLK),
    .nRST     (nRST),
    .start    (start),
    .vcmd     (vcmd),
    .elem_req (elem_req),
    .busy     (busy),
    .done     (done)
  );

  // reads and write-back share the same request cycle
  vec_reg_file u_rf (
    .CLK       (CLK),
    .nRST      (nRST),
    .elem_req  (elem_req),
    .src_ops   (src_ops),
    .wb        (wb),
    .rd_vreg   (rd_vreg),
    .rd_offset (rd_offset),
    .rd_sew    (rd_sew),
    .rd_data   (rd_data)
  );

  vec_lane_alu u_alu (
    .elem_req (elem_req),
    .src_ops  (src_ops),
    .wb       (wb)
  );

endmodule
